// ==== adapter/cacheline_adapter.sv ====
`timescale 1ns/1ns

module cacheline_adapter (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      line_read,
    input  logic                      line_write,
    input  cache_mem_pkg::line_addr_t line_addr,
    input  cache_mem_pkg::line_data_t line_wdata,
    output logic                      line_ready,
    output logic                      line_rvalid,
    output cache_mem_pkg::line_data_t line_rdata,
    output cache_mem_pkg::line_addr_t line_raddr,

    output logic                      mem_read,
    output logic                      mem_write,
    output cache_mem_pkg::line_addr_t mem_addr,
    output cache_mem_pkg::beat_data_t mem_wdata,
    input  cache_mem_pkg::beat_data_t mem_rdata,
    input  logic                      mem_resp
);

    localparam cache_mem_pkg::beat_idx_t LAST_BEAT =
        cache_mem_pkg::beat_idx_t'(cache_mem_pkg::BEATS_PER_LINE - 1);

    cache_mem_pkg::adapt_state_t state;
    cache_mem_pkg::adapt_state_t state_next;

    cache_mem_pkg::beat_idx_t  beat_cnt;
    cache_mem_pkg::line_addr_t req_addr;
    cache_mem_pkg::line_data_t rd_line;                   // read beats gathered here
    logic                      req_write;
    logic                      last_resp;

    assign last_resp = (state == cache_mem_pkg::BURST) && mem_resp && (beat_cnt == LAST_BEAT);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= cache_mem_pkg::IDLE;
            beat_cnt  <= '0;
            req_write <= 1'b0;
        end else begin
            state <= state_next;
            if (state == cache_mem_pkg::IDLE) begin
                beat_cnt <= '0;
                if (line_read || line_write) begin
                    req_write <= line_write;              // direction fixed for the whole burst
                end
            end else if ((state == cache_mem_pkg::BURST) && mem_resp) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // request address and the read line being gathered
    always_ff @(posedge clk) begin
        if ((state == cache_mem_pkg::IDLE) && (line_read || line_write)) begin
            req_addr <= line_addr;
        end
        if ((state == cache_mem_pkg::BURST) && mem_resp && !req_write) begin
            // lowest beat arrives first, so it ends up in the bottom slot
            rd_line <= {mem_rdata, rd_line[cache_mem_pkg::LINE_WIDTH-1:cache_mem_pkg::BEAT_WIDTH]};
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            cache_mem_pkg::IDLE: begin
                if (line_read || line_write) begin
                    state_next = cache_mem_pkg::BURST;
                end
            end
            cache_mem_pkg::BURST: begin
                if (last_resp) begin
                    state_next = cache_mem_pkg::DONE;
                end
            end
            cache_mem_pkg::DONE: begin
                state_next = cache_mem_pkg::IDLE;         // request drops here for one cycle
            end
            default: begin
                state_next = cache_mem_pkg::IDLE;
            end
        endcase
    end

    assign mem_read  = (state == cache_mem_pkg::BURST) && !req_write;
    assign mem_write = (state == cache_mem_pkg::BURST) && req_write;
    assign mem_addr  = req_addr;

    // the arbiter keeps line_wdata stable until line_ready, so beats come straight from it
    assign mem_wdata = line_wdata[beat_cnt * cache_mem_pkg::BEAT_WIDTH +: cache_mem_pkg::BEAT_WIDTH];

    assign line_ready  = (state == cache_mem_pkg::DONE);
    assign line_rvalid = (state == cache_mem_pkg::DONE) && !req_write;
    assign line_rdata  = rd_line;
    assign line_raddr  = req_addr;

endmodule

// ==== arbiter/cache_arbiter.sv ====
`timescale 1ns/1ns

module cache_arbiter (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    icache_read,
    input  logic                    dcache_read,
    input  logic                    dcache_write,
    input  cache_mem_pkg::line_addr_t icache_addr,
    input  cache_mem_pkg::line_addr_t dcache_addr,
    input  cache_mem_pkg::line_data_t dcache_wdata,

    output logic                    icache_ready,
    output logic                    dcache_ready,
    output logic                    icache_rvalid,
    output logic                    dcache_rvalid,
    output cache_mem_pkg::line_data_t icache_rdata,
    output cache_mem_pkg::line_data_t dcache_rdata,
    output cache_mem_pkg::line_addr_t icache_raddr,
    output cache_mem_pkg::line_addr_t dcache_raddr,

    output logic                    line_read,
    output logic                    line_write,
    output cache_mem_pkg::line_addr_t line_addr,
    output cache_mem_pkg::line_data_t line_wdata,
    input  logic                    line_ready,
    input  logic                    line_rvalid,
    input  cache_mem_pkg::line_data_t line_rdata,
    input  cache_mem_pkg::line_addr_t line_raddr
);

    cache_mem_pkg::arb_state_t state;
    cache_mem_pkg::arb_state_t state_next;

    cache_mem_pkg::line_addr_t hold_addr;
    cache_mem_pkg::line_data_t hold_wdata;

    logic icache_owner;                                   // icache read is already in the adapter
    logic dcache_req;
    logic dcache_grant;
    logic icache_grant;

    assign dcache_req   = dcache_read || dcache_write;
    assign dcache_grant = (state == cache_mem_pkg::PASS_THRU) && dcache_req && !icache_owner;
    assign icache_grant = (state == cache_mem_pkg::PASS_THRU) && icache_read &&
                          (icache_owner || !dcache_req);

    // the write latch lets dcache drop its request once the write is accepted
    always_ff @(posedge clk) begin
        if (dcache_grant && dcache_write) begin
            hold_addr  <= dcache_addr;
            hold_wdata <= dcache_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= cache_mem_pkg::PASS_THRU;
            icache_owner <= 1'b0;
        end else begin
            state <= state_next;
            if (line_ready) begin
                icache_owner <= 1'b0;                     // burst finished so the grant is released
            end else if (icache_grant) begin
                icache_owner <= 1'b1;                     // keep icache until its line is done
            end
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            cache_mem_pkg::PASS_THRU: begin
                if (dcache_grant && dcache_write && !line_ready) begin
                    state_next = cache_mem_pkg::WAIT_WRITE;
                end
            end
            cache_mem_pkg::WAIT_WRITE: begin
                if (line_ready) begin
                    state_next = cache_mem_pkg::PASS_THRU;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        line_read    = 1'b0;
        line_write   = 1'b0;
        line_addr    = '0;
        line_wdata   = '0;
        icache_ready = 1'b0;
        dcache_ready = 1'b0;
        unique case (state)
            cache_mem_pkg::PASS_THRU: begin
                if (dcache_grant) begin
                    line_read    = dcache_read;
                    line_write   = dcache_write;
                    line_addr    = dcache_addr;
                    line_wdata   = dcache_wdata;
                    dcache_ready = line_ready;
                end else if (icache_grant) begin
                    line_read    = 1'b1;                  // icache never writes
                    line_addr    = icache_addr;
                    icache_ready = line_ready;
                end
            end
            cache_mem_pkg::WAIT_WRITE: begin
                line_write   = 1'b1;
                line_addr    = hold_addr;
                line_wdata   = hold_wdata;
                dcache_ready = line_ready;
            end
            default: ;
        endcase
    end

    // every returned line goes to both caches and each one matches raddr itself
    assign icache_rdata  = line_rdata;
    assign dcache_rdata  = line_rdata;
    assign icache_raddr  = line_raddr;
    assign dcache_raddr  = line_raddr;
    assign icache_rvalid = line_rvalid;
    assign dcache_rvalid = line_rvalid;

endmodule

// ==== common/cache_mem_pkg.sv ====
package cache_mem_pkg;

    localparam int ADDR_WIDTH     = 32;
    localparam int BEAT_WIDTH     = 64;
    localparam int BEATS_PER_LINE = 4;                    // beats moved per line burst
    localparam int LINE_WIDTH     = BEAT_WIDTH * BEATS_PER_LINE;
    localparam int BEAT_IDX_WIDTH = $clog2(BEATS_PER_LINE);

    // byte address of a line whose low five bits are always zero
    typedef logic [ADDR_WIDTH-1:0] line_addr_t;

    typedef logic [LINE_WIDTH-1:0] line_data_t;           // one full cache line

    typedef logic [BEAT_WIDTH-1:0] beat_data_t;           // one burst beat on the memory port

    typedef logic [BEAT_IDX_WIDTH-1:0] beat_idx_t;        // position of a beat inside its line

    // arbiter grant state
    typedef enum logic {
        PASS_THRU,                                        // requests pass straight to the adapter
        WAIT_WRITE                                        // latched dcache write is being served
    } arb_state_t;

    // line adapter burst state
    typedef enum logic [1:0] {
        IDLE,                                             // waiting for a line request
        BURST,                                            // beats moving on the memory port
        DONE                                              // line complete and ready pulses
    } adapt_state_t;

endpackage

// ==== src.f ====
common/cache_mem_pkg.sv
arbiter/cache_arbiter.sv
adapter/cacheline_adapter.sv
verilog/mem_subsys_top.sv
verification/tb_clock_gen.sv
verification/burst_mem_model.sv
verification/mem_subsys_checker.sv
verification/mem_subsys_tb.sv

// ==== verification/burst_mem_model.sv ====
`timescale 1ns/1ns

module burst_mem_model #(
    parameter logic [63:0] FILL = 64'h0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      mem_read,
    input  logic                      mem_write,
    input  cache_mem_pkg::line_addr_t mem_addr,
    input  cache_mem_pkg::beat_data_t mem_wdata,
    output cache_mem_pkg::beat_data_t mem_rdata,
    output logic                      mem_resp
);

    localparam cache_mem_pkg::beat_idx_t LAST_BEAT =
        cache_mem_pkg::beat_idx_t'(cache_mem_pkg::BEATS_PER_LINE - 1);

    cache_mem_pkg::beat_data_t words [256];               // 2 KiB window with one word per 8 bytes
    cache_mem_pkg::beat_idx_t  beat;
    logic [1:0]                wait_cnt;
    logic [1:0]                draw;
    logic                      finished;
    logic [31:0]               lfsr;
    logic [7:0]                word_idx;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step for every bit of the wait count
    task automatic draw_wait(output logic [1:0] w);
        for (int k = 0; k < 2; k++) begin
            w[k] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    initial begin
        lfsr = 32'h524a_acb0;
        for (int i = 0; i < 256; i++) begin
            words[i] = 64'(i) ^ FILL;
        end
    end

    assign word_idx  = {mem_addr[10:5], beat};
    assign mem_rdata = words[word_idx];

    always @(posedge clk) begin
        if (rst || !(mem_read || mem_write)) begin
            mem_resp <= 1'b0;
            beat     <= '0;
            finished <= 1'b0;
            draw_wait(draw);
            wait_cnt <= draw;
        end else if (mem_resp) begin
            if (mem_write) begin
                words[word_idx] <= mem_wdata;
            end
            beat <= beat + 1'b1;
            if (beat == LAST_BEAT) begin
                finished <= 1'b1;                         // no more beats until the request drops
                mem_resp <= 1'b0;
            end else begin
                draw_wait(draw);
                mem_resp <= (draw == 2'd0);               // zero wait gives back-to-back beats
                wait_cnt <= draw - 1'b1;
            end
        end else if (!finished) begin
            if (wait_cnt == 2'd0) begin
                mem_resp <= 1'b1;
            end else begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

endmodule

// ==== verification/mem_subsys_checker.sv ====
`timescale 1ns/1ns

module mem_subsys_checker (
    input logic                      clk,
    input logic                      rst,
    input logic                      icache_ready,
    input logic                      dcache_ready,
    input logic                      mem_read,
    input logic                      mem_write,
    input logic                      line_write,
    input logic                      line_ready,
    input cache_mem_pkg::arb_state_t arb_state
);

    int unsigned assert_errors = 0;                       // number of failed assertions

    // ready goes to one cache only and lasts a single cycle
    one_ready: assert property (@(posedge clk) disable iff (rst)
        !(icache_ready && dcache_ready) &&
        !($past(icache_ready || dcache_ready) && (icache_ready || dcache_ready)))
        else begin
            assert_errors++;
            $error("ready high on both cache ports or for two cycles in a row");
        end

    // a burst keeps one direction and never turns around without an idle cycle
    one_direction: assert property (@(posedge clk) disable iff (rst)
        !(mem_read && mem_write) &&
        !(mem_read && $past(mem_write)) && !(mem_write && $past(mem_read)))
        else begin
            assert_errors++;
            $error("mem_read and mem_write overlap or follow each other directly");
        end

    // the latched write must stay on the line port until the adapter finishes it
    write_held: assert property (@(posedge clk) disable iff (rst)
        (line_write && !line_ready) |=>
        ((arb_state == cache_mem_pkg::WAIT_WRITE) && line_write))
        else begin
            assert_errors++;
            $error("line_write dropped before the adapter finished the write");
        end

endmodule

bind mem_subsys_top mem_subsys_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .icache_ready (icache_ready),
    .dcache_ready (dcache_ready),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .line_write   (line_write),
    .line_ready   (line_ready),
    .arb_state    (u_arbiter.state)
);

// ==== verification/mem_subsys_tb.sv ====
`timescale 1ns/1ns

module mem_subsys_tb;

    localparam int          TIMEOUT  = 200;
    localparam logic [63:0] MEM_FILL = 64'h5a3c_c3a5_0f1e_e1f0;

    typedef enum logic [1:0] {NO_WIN, ICACHE_WIN, DCACHE_WIN} winner_t;

    typedef struct {
        logic                      ireq;
        logic                      dreq;
        logic                      dwrite;
        logic                      drop;                  // dcache lets go after one cycle
        cache_mem_pkg::line_addr_t iaddr;
        cache_mem_pkg::line_addr_t daddr;
        cache_mem_pkg::line_data_t wdata;
        winner_t                   winner;
    } row_t;

    logic clk;
    logic rst;
    logic icache_read;
    logic dcache_read;
    logic dcache_write;
    cache_mem_pkg::line_addr_t icache_addr;
    cache_mem_pkg::line_addr_t dcache_addr;
    cache_mem_pkg::line_data_t dcache_wdata;
    logic icache_ready;
    logic dcache_ready;
    logic icache_rvalid;
    logic dcache_rvalid;
    cache_mem_pkg::line_data_t icache_rdata;
    cache_mem_pkg::line_data_t dcache_rdata;
    cache_mem_pkg::line_addr_t icache_raddr;
    cache_mem_pkg::line_addr_t dcache_raddr;
    logic mem_read;
    logic mem_write;
    logic mem_resp;
    cache_mem_pkg::line_addr_t mem_addr;
    cache_mem_pkg::beat_data_t mem_wdata;
    cache_mem_pkg::beat_data_t mem_rdata;

    cache_mem_pkg::beat_data_t shadow [256];
    row_t rows[$];
    int   data_errors = 0;
    int   addr_errors = 0;
    int   flag_errors = 0;
    int   order_errors = 0;
    logic timed_out = 1'b0;

    tb_clock_gen clock_gen (.clk(clk), .rst(rst));

    burst_mem_model #(.FILL(MEM_FILL)) memory (
        .clk(clk), .rst(rst), .mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_resp(mem_resp)
    );

    mem_subsys_top uut (.*);

    task automatic line_check(input string what, input cache_mem_pkg::line_data_t got,
                              input cache_mem_pkg::line_data_t exp);
        if (got !== exp) begin
            data_errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic addr_check(input string what, input cache_mem_pkg::line_addr_t got,
                              input cache_mem_pkg::line_addr_t exp);
        if (got !== exp) begin
            addr_errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic flag_check(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic winner_check(input string what, input winner_t got, input winner_t exp);
        if (got !== exp) begin
            order_errors++;
            $display("FAIL %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    // the low beat of a line sits at the lowest word address
    function automatic cache_mem_pkg::line_data_t shadow_line(input cache_mem_pkg::line_addr_t a);
        cache_mem_pkg::line_data_t l;
        for (int b = 0; b < cache_mem_pkg::BEATS_PER_LINE; b++) begin
            l[b*64 +: 64] = shadow[{a[10:5], 2'(b)}];
        end
        return l;
    endfunction

    function automatic cache_mem_pkg::line_data_t pattern_line(input logic [31:0] tag);
        cache_mem_pkg::line_data_t l;
        for (int b = 0; b < cache_mem_pkg::BEATS_PER_LINE; b++) begin
            l[b*64 +: 64] = {tag, 32'(b) ^ 32'hbeef_0000};
        end
        return l;
    endfunction

    function automatic row_t make_row(input logic ireq, input logic dreq, input logic dwrite,
                                      input logic drop, input logic [31:0] iaddr,
                                      input logic [31:0] daddr, input logic [31:0] tag,
                                      input winner_t winner);
        row_t r;
        r = '{ireq, dreq, dwrite, drop, iaddr, daddr, pattern_line(tag), winner};
        return r;
    endfunction

    // a read return is broadcast, so both ports must show it
    task automatic return_check(input string who, input cache_mem_pkg::line_addr_t a);
        cache_mem_pkg::line_data_t exp;
        exp = shadow_line(a);
        flag_check({who, " icache_rvalid"}, icache_rvalid, 1'b1);
        flag_check({who, " dcache_rvalid"}, dcache_rvalid, 1'b1);
        line_check({who, " icache_rdata"}, icache_rdata, exp);
        line_check({who, " dcache_rdata"}, dcache_rdata, exp);
        addr_check({who, " icache_raddr"}, icache_raddr, a);
        addr_check({who, " dcache_raddr"}, dcache_raddr, a);
    endtask

    task automatic apply_row(input row_t r);
        int      cycles;
        int      i_st;                                    // 0 waiting, 1 ready seen, 2 released
        int      d_st;
        logic    i_now;
        logic    d_now;
        winner_t first;
        cycles       = 0;
        i_st         = r.ireq ? 0 : 2;
        d_st         = r.dreq ? 0 : 2;
        first        = NO_WIN;
        icache_read  = r.ireq;
        icache_addr  = r.iaddr;
        dcache_read  = r.dreq && !r.dwrite;
        dcache_write = r.dreq && r.dwrite;
        dcache_addr  = r.daddr;
        dcache_wdata = r.wdata;
        while ((i_st != 2 || d_st != 2) && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            // dcache is served first whenever it still waits
            if (mem_read || mem_write) begin
                addr_check("mem_addr", mem_addr, (d_st == 0) ? r.daddr : r.iaddr);
            end
            i_now = (i_st == 0) && icache_ready;
            d_now = (d_st == 0) && dcache_ready;
            if (first == NO_WIN && (i_now || d_now)) begin
                first = d_now ? DCACHE_WIN : ICACHE_WIN;
                flag_check("request to ready takes at least six cycles", cycles >= 6, 1'b1);
            end
            if (i_now) begin
                return_check("icache read", r.iaddr);
            end
            if (d_now && r.dwrite) begin
                for (int b = 0; b < cache_mem_pkg::BEATS_PER_LINE; b++) begin
                    shadow[{r.daddr[10:5], 2'(b)}] = r.wdata[b*64 +: 64];
                end
                flag_check("dcache_rvalid on write", dcache_rvalid, 1'b0);
                flag_check("icache_rvalid on write", icache_rvalid, 1'b0);
            end else if (d_now) begin
                return_check("dcache read", r.daddr);
            end
            if (i_st == 1) begin
                icache_read = 1'b0;
                i_st        = 2;
            end
            if (d_st == 1) begin
                dcache_read  = 1'b0;
                dcache_write = 1'b0;
                d_st         = 2;
            end
            i_st = i_now ? 1 : i_st;
            d_st = d_now ? 1 : d_st;
            if (r.drop && cycles == 1) begin
                dcache_write = 1'b0;
            end
        end
        if (i_st != 2 || d_st != 2) begin
            $display("timeout: no ready within %0d cycles at time %0t", TIMEOUT, $time);
            timed_out = 1'b1;
        end else begin
            winner_check("first ready", first, r.winner);
        end
    endtask

    initial begin
        int cycles;
        icache_read  = 1'b0;
        dcache_read  = 1'b0;
        dcache_write = 1'b0;
        icache_addr  = '0;
        dcache_addr  = '0;
        dcache_wdata = '0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = 64'(i) ^ MEM_FILL;
        end
        //                    ireq dreq wr drop iaddr      daddr      tag        winner
        rows.push_back(make_row(1, 0, 0, 0, 32'h0000_0040, 32'h0, 32'h0, ICACHE_WIN));
        rows.push_back(make_row(0, 1, 1, 0, 32'h0, 32'h0000_0080, 32'h1111_0080, DCACHE_WIN));
        rows.push_back(make_row(0, 1, 0, 0, 32'h0, 32'h0000_0080, 32'h0, DCACHE_WIN));
        rows.push_back(make_row(1, 0, 0, 0, 32'h0000_0080, 32'h0, 32'h0, ICACHE_WIN));
        rows.push_back(make_row(1, 1, 0, 0, 32'h0000_0100, 32'h0000_0140, 32'h0, DCACHE_WIN));
        rows.push_back(make_row(1, 1, 1, 0, 32'h0000_01a0, 32'h0000_01a0, 32'h2222_01a0,
                                DCACHE_WIN));
        rows.push_back(make_row(0, 1, 1, 1, 32'h0, 32'h0000_0200, 32'h3333_0200, DCACHE_WIN));
        rows.push_back(make_row(0, 1, 0, 0, 32'h0, 32'h0000_0200, 32'h0, DCACHE_WIN));
        rows.push_back(make_row(1, 0, 0, 0, 32'h0000_0240, 32'h0, 32'h0, ICACHE_WIN));
        rows.push_back(make_row(0, 1, 0, 0, 32'h0, 32'h0000_0280, 32'h0, DCACHE_WIN));
        rows.push_back(make_row(1, 0, 0, 0, 32'h0000_02c0, 32'h0, 32'h0, ICACHE_WIN));
        rows.push_back(make_row(0, 1, 0, 0, 32'h0, 32'h0000_07e0, 32'h0, DCACHE_WIN));
        rows.push_back(make_row(1, 1, 0, 0, 32'h0000_0300, 32'h0000_0000, 32'h0, DCACHE_WIN));
        cycles = 0;
        while (rst !== 1'b0 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (rst !== 1'b0) begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
        end else begin
            repeat (3) begin
                @(negedge clk);
                flag_check("outputs idle after reset", |{icache_ready, dcache_ready,
                           icache_rvalid, dcache_rvalid, mem_read, mem_write}, 1'b0);
            end
        end
        for (int k = 0; k < rows.size() && !timed_out; k++) begin
            apply_row(rows[k]);
        end
        $display("errors: data %0d, addr %0d, flag %0d, order %0d, assertion %0d",
                 data_errors, addr_errors, flag_errors, order_errors,
                 uut.u_checker.assert_errors);
        if (timed_out || (data_errors + addr_errors + flag_errors + order_errors) != 0 ||
            uut.u_checker.assert_errors != 0) begin
            $display("Some tests failed");
        end else begin
            $display("All tests passed");
        end
        $finish;
    end

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                            // 10 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;                                       // released on a falling edge like all inputs
    end

endmodule

// ==== verilog/mem_subsys_top.sv ====
`timescale 1ns/1ns

module mem_subsys_top (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      icache_read,
    input  logic                      dcache_read,
    input  logic                      dcache_write,
    input  cache_mem_pkg::line_addr_t icache_addr,
    input  cache_mem_pkg::line_addr_t dcache_addr,
    input  cache_mem_pkg::line_data_t dcache_wdata,
    output logic                      icache_ready,
    output logic                      dcache_ready,
    output logic                      icache_rvalid,
    output logic                      dcache_rvalid,
    output cache_mem_pkg::line_data_t icache_rdata,
    output cache_mem_pkg::line_data_t dcache_rdata,
    output cache_mem_pkg::line_addr_t icache_raddr,
    output cache_mem_pkg::line_addr_t dcache_raddr,

    output logic                      mem_read,
    output logic                      mem_write,
    output cache_mem_pkg::line_addr_t mem_addr,
    output cache_mem_pkg::beat_data_t mem_wdata,
    input  cache_mem_pkg::beat_data_t mem_rdata,
    input  logic                      mem_resp
);

    logic                      line_read;
    logic                      line_write;
    cache_mem_pkg::line_addr_t line_addr;
    cache_mem_pkg::line_data_t line_wdata;
    logic                      line_ready;
    logic                      line_rvalid;
    cache_mem_pkg::line_data_t line_rdata;
    cache_mem_pkg::line_addr_t line_raddr;

    cache_arbiter u_arbiter (
        .clk           (clk),
        .rst           (rst),
        .icache_read   (icache_read),
        .dcache_read   (dcache_read),
        .dcache_write  (dcache_write),
        .icache_addr   (icache_addr),
        .dcache_addr   (dcache_addr),
        .dcache_wdata  (dcache_wdata),
        .icache_ready  (icache_ready),
        .dcache_ready  (dcache_ready),
        .icache_rvalid (icache_rvalid),
        .dcache_rvalid (dcache_rvalid),
        .icache_rdata  (icache_rdata),
        .dcache_rdata  (dcache_rdata),
        .icache_raddr  (icache_raddr),
        .dcache_raddr  (dcache_raddr),
        .line_read     (line_read),
        .line_write    (line_write),
        .line_addr     (line_addr),
        .line_wdata    (line_wdata),
        .line_ready    (line_ready),
        .line_rvalid   (line_rvalid),
        .line_rdata    (line_rdata),
        .line_raddr    (line_raddr)
    );

    cacheline_adapter u_adapter (
        .clk         (clk),
        .rst         (rst),
        .line_read   (line_read),
        .line_write  (line_write),
        .line_addr   (line_addr),
        .line_wdata  (line_wdata),
        .line_ready  (line_ready),
        .line_rvalid (line_rvalid),
        .line_rdata  (line_rdata),
        .line_raddr  (line_raddr),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_resp    (mem_resp)
    );

endmodule
